// ==== hw/uart_pkg.sv ====
package uart_pkg;

    // Host command codes
    localparam logic [7:0] CMD_UART_CONFIG = 8'h07;
    localparam logic [7:0] CMD_UART_TX     = 8'h08;
    localparam logic [7:0] CMD_UART_RX     = 8'h09;

    // Queue sizing shared by both FIFOs
    localparam int FIFO_DEPTH  = 16;
    localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);

    // Config payload is divisor (4 bytes, MSB first), data bits, stop, parity
    localparam int CFG_BYTES = 7;

    // Parity selection
    localparam logic [1:0] PAR_NONE = 2'd0;
    localparam logic [1:0] PAR_ODD  = 2'd1;
    localparam logic [1:0] PAR_EVEN = 2'd2;

    typedef struct packed {
        logic [31:0] divisor;
        logic [3:0]  data_bits;
        logic        two_stop;
        logic [1:0]  parity;
    } uart_cfg_t;

    // 8N1 at 16 clocks per bit
    localparam uart_cfg_t CFG_DEFAULT = '{
        divisor:   32'd16,
        data_bits: 4'd8,
        two_stop:  1'b0,
        parity:    PAR_NONE
    };

    typedef struct packed {
        logic [7:0] data;
        logic       parity_err;
        logic       frame_err;
    } uart_rx_entry_t;

    typedef struct packed {
        logic [7:0] data;
        logic [2:0] index;
    } cmd_beat_t;

endpackage

// ==== hw/sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo
    import uart_pkg::*;
#(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);

    payload_t              mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  do_push;
    logic                  do_pop;

    // Overfull pushes and empty pops are dropped here
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full     = (count == (FIFO_PTR_W + 1)'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Occupancy only moves when exactly one side fires
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== hw/uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx
    import uart_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  uart_cfg_t cfg,
    input  logic [7:0] tx_data,
    input  logic      tx_valid,
    output logic      tx_busy,
    output logic      txd
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_PARITY,
        S_STOP
    } tx_state_t;

    tx_state_t   state;
    logic [31:0] bit_cnt;
    logic [2:0]  bit_idx;
    logic [7:0]  shreg;
    logic        par_acc;
    logic        second_stop;
    logic        bit_end;
    logic        last_data;
    logic        par_on;
    logic        par_next;

    assign bit_end   = (bit_cnt == cfg.divisor - 32'd1);
    assign last_data = ({1'b0, bit_idx} == cfg.data_bits - 4'd1);
    assign par_on    = (cfg.parity == PAR_ODD) || (cfg.parity == PAR_EVEN);
    // Running parity including the bit currently on the line
    assign par_next  = par_acc ^ shreg[0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= S_IDLE;
            bit_cnt     <= '0;
            bit_idx     <= '0;
            shreg       <= '0;
            par_acc     <= 1'b0;
            second_stop <= 1'b0;
            tx_busy     <= 1'b0;
            txd         <= 1'b1;
        end else begin
            if (state != S_IDLE) begin
                bit_cnt <= bit_end ? '0 : bit_cnt + 32'd1;
            end
            case (state)
                S_IDLE: begin
                    if (tx_valid) begin
                        shreg       <= tx_data;
                        par_acc     <= 1'b0;
                        second_stop <= 1'b0;
                        bit_cnt     <= '0;
                        tx_busy     <= 1'b1;
                        txd         <= 1'b0;
                        state       <= S_START;
                    end
                end
                S_START: begin
                    if (bit_end) begin
                        bit_idx <= '0;
                        txd     <= shreg[0];
                        state   <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (bit_end) begin
                        par_acc <= par_next;
                        shreg   <= shreg >> 1;
                        if (!last_data) begin
                            bit_idx <= bit_idx + 3'd1;
                            txd     <= shreg[1];
                        end else if (par_on) begin
                            txd   <= (cfg.parity == PAR_ODD) ? ~par_next : par_next;
                            state <= S_PARITY;
                        end else begin
                            txd   <= 1'b1;
                            state <= S_STOP;
                        end
                    end
                end
                S_PARITY: begin
                    if (bit_end) begin
                        txd   <= 1'b1;
                        state <= S_STOP;
                    end
                end
                S_STOP: begin
                    if (bit_end) begin
                        if (cfg.two_stop && !second_stop) begin
                            second_stop <= 1'b1;
                        end else begin
                            tx_busy <= 1'b0;
                            state   <= S_IDLE;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx
    import uart_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  uart_cfg_t      cfg,
    input  logic           rxd,
    output uart_rx_entry_t rx_entry,
    output logic           rx_valid
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_PARITY,
        S_STOP
    } rx_state_t;

    rx_state_t   state;
    logic        rxd_meta;
    logic        rxd_sync;
    logic        rxd_prev;
    logic [31:0] bit_cnt;
    logic [2:0]  bit_idx;
    logic [7:0]  data_q;
    logic        par_acc;
    logic        parity_err_q;
    logic        half_point;
    logic        sample_point;
    logic        last_data;
    logic        par_on;

    assign half_point   = (bit_cnt == (cfg.divisor >> 1));
    assign sample_point = (bit_cnt == cfg.divisor - 32'd1);
    assign last_data    = ({1'b0, bit_idx} == cfg.data_bits - 4'd1);
    assign par_on       = (cfg.parity == PAR_ODD) || (cfg.parity == PAR_EVEN);

    // Two-flop synchronizer plus edge history
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            par_acc  <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            bit_cnt  <= bit_cnt + 32'd1;
            case (state)
                S_IDLE: begin
                    bit_cnt <= '0;
                    if (rxd_prev && !rxd_sync) begin
                        state <= S_START;
                    end
                end
                S_START: begin
                    if (half_point) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        par_acc <= 1'b0;
                        // A high line here was only a glitch
                        state   <= rxd_sync ? S_IDLE : S_DATA;
                    end
                end
                S_DATA: begin
                    if (sample_point) begin
                        bit_cnt <= '0;
                        par_acc <= par_acc ^ rxd_sync;
                        bit_idx <= bit_idx + 3'd1;
                        if (last_data) begin
                            state <= par_on ? S_PARITY : S_STOP;
                        end
                    end
                end
                S_PARITY: begin
                    if (sample_point) begin
                        bit_cnt <= '0;
                        state   <= S_STOP;
                    end
                end
                S_STOP: begin
                    // Entry goes out mid first stop bit
                    if (sample_point) begin
                        rx_valid <= 1'b1;
                        state    <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Frame payload
    always_ff @(posedge clk) begin
        if (state == S_START && half_point) begin
            data_q       <= '0;
            parity_err_q <= 1'b0;
        end
        if (state == S_DATA && sample_point) begin
            data_q[bit_idx] <= rxd_sync;
        end
        if (state == S_PARITY && sample_point) begin
            parity_err_q <= (rxd_sync != (par_acc ^ (cfg.parity == PAR_ODD)));
        end
        if (state == S_STOP && sample_point) begin
            rx_entry <= '{data: data_q, parity_err: parity_err_q, frame_err: !rxd_sync};
        end
    end

endmodule

// ==== hw/uart_handler.sv ====
`timescale 1ns/1ns

module uart_handler
    import uart_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic [7:0]     cmd_type,
    input  logic           cmd_start,
    input  cmd_beat_t      cmd_beat,
    input  logic           cmd_valid,
    input  logic           cmd_done,
    output logic           cmd_ready,
    output uart_rx_entry_t rsp,
    output logic           rsp_valid,
    input  logic           rsp_ready,
    output uart_cfg_t      cfg,
    output logic           tx_push,
    output logic [7:0]     tx_push_data,
    input  logic           tx_full,
    input  logic           tx_empty,
    output logic           tx_pop,
    input  logic [7:0]     tx_pop_data,
    output logic [7:0]     tx_data,
    output logic           tx_valid,
    input  logic           tx_busy,
    output logic           rx_pop,
    input  uart_rx_entry_t rx_pop_data,
    input  logic           rx_empty
);

    typedef enum logic [2:0] {
        IDLE,
        RX_CONFIG,
        UPDATE_CFG,
        RX_TX_DATA,
        HANDLE_RX
    } handler_state_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_SEND,
        SEQ_WAIT
    } seq_state_t;

    handler_state_t state;
    seq_state_t     seq_state;
    logic [7:0]     cfg_bytes [CFG_BYTES];

    // Host side handshake
    assign cmd_ready = (state == IDLE) || (state == RX_CONFIG) ||
                       ((state == RX_TX_DATA) && !tx_full);

    assign tx_push      = (state == RX_TX_DATA) && cmd_valid && !tx_full;
    assign tx_push_data = cmd_beat.data;

    // Response path straight off the RX FIFO head
    assign rsp       = rx_pop_data;
    assign rsp_valid = (state == HANDLE_RX) && !rx_empty;
    assign rx_pop    = rsp_valid && rsp_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            cfg   <= CFG_DEFAULT;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_start) begin
                        case (cmd_type)
                            CMD_UART_CONFIG: state <= RX_CONFIG;
                            CMD_UART_TX:     state <= RX_TX_DATA;
                            CMD_UART_RX:     state <= HANDLE_RX;
                            default:         state <= IDLE;
                        endcase
                    end
                end
                RX_CONFIG: begin
                    if (cmd_done) begin
                        state <= UPDATE_CFG;
                    end
                end
                UPDATE_CFG: begin
                    cfg.divisor   <= {cfg_bytes[0], cfg_bytes[1], cfg_bytes[2], cfg_bytes[3]};
                    cfg.data_bits <= cfg_bytes[4][3:0];
                    cfg.two_stop  <= |cfg_bytes[5];
                    cfg.parity    <= cfg_bytes[6][1:0];
                    state         <= IDLE;
                end
                RX_TX_DATA, HANDLE_RX: begin
                    if (cmd_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Config bytes stored by beat index up to the payload size
    always_ff @(posedge clk) begin
        if (state == RX_CONFIG && cmd_valid && (int'(cmd_beat.index) < CFG_BYTES)) begin
            cfg_bytes[cmd_beat.index] <= cmd_beat.data;
        end
    end

    // Valid stays up until the transmitter picks the byte up
    assign tx_valid = (seq_state == SEQ_SEND);
    assign tx_pop   = (seq_state == SEQ_SEND) && tx_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seq_state <= SEQ_IDLE;
        end else begin
            case (seq_state)
                SEQ_IDLE: begin
                    if (!tx_empty) begin
                        seq_state <= SEQ_SEND;
                    end
                end
                SEQ_SEND: begin
                    if (tx_busy) begin
                        seq_state <= SEQ_WAIT;
                    end
                end
                SEQ_WAIT: begin
                    if (!tx_busy) begin
                        seq_state <= SEQ_IDLE;
                    end
                end
                default: seq_state <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (seq_state == SEQ_IDLE && !tx_empty) begin
            tx_data <= tx_pop_data;
        end
    end

endmodule

// ==== hw/uart_bridge_top.sv ====
`timescale 1ns/1ns

module uart_bridge_top
    import uart_pkg::*;
(
    input  logic           clk,
    input  logic           rst_n,
    input  logic [7:0]     cmd_type,
    input  logic           cmd_start,
    input  cmd_beat_t      cmd_beat,
    input  logic           cmd_valid,
    input  logic           cmd_done,
    output logic           cmd_ready,
    output uart_rx_entry_t rsp,
    output logic           rsp_valid,
    input  logic           rsp_ready,
    output logic           uart_txd,
    input  logic           uart_rxd
);

    uart_cfg_t      cfg;
    logic           tx_push;
    logic [7:0]     tx_push_data;
    logic           tx_pop;
    logic [7:0]     tx_pop_data;
    logic           tx_full;
    logic           tx_empty;
    logic [7:0]     tx_data;
    logic           tx_valid;
    logic           tx_busy;
    uart_rx_entry_t rx_entry;
    logic           rx_valid;
    logic           rx_pop;
    uart_rx_entry_t rx_pop_data;
    logic           rx_empty;

    uart_handler i_uart_handler (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_type     (cmd_type),
        .cmd_start    (cmd_start),
        .cmd_beat     (cmd_beat),
        .cmd_valid    (cmd_valid),
        .cmd_done     (cmd_done),
        .cmd_ready    (cmd_ready),
        .rsp          (rsp),
        .rsp_valid    (rsp_valid),
        .rsp_ready    (rsp_ready),
        .cfg          (cfg),
        .tx_push      (tx_push),
        .tx_push_data (tx_push_data),
        .tx_full      (tx_full),
        .tx_empty     (tx_empty),
        .tx_pop       (tx_pop),
        .tx_pop_data  (tx_pop_data),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid),
        .tx_busy      (tx_busy),
        .rx_pop       (rx_pop),
        .rx_pop_data  (rx_pop_data),
        .rx_empty     (rx_empty)
    );

    // Bytes queued for the line
    sync_fifo #(
        .payload_t (logic [7:0])
    ) i_tx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (tx_push),
        .push_data (tx_push_data),
        .pop       (tx_pop),
        .pop_data  (tx_pop_data),
        .full      (tx_full),
        .empty     (tx_empty)
    );

    // Received entries that arrive while full are dropped
    sync_fifo #(
        .payload_t (uart_rx_entry_t)
    ) i_rx_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rx_valid),
        .push_data (rx_entry),
        .pop       (rx_pop),
        .pop_data  (rx_pop_data),
        .full      (),
        .empty     (rx_empty)
    );

    uart_tx i_uart_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg      (cfg),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_busy  (tx_busy),
        .txd      (uart_txd)
    );

    uart_rx i_uart_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .cfg      (cfg),
        .rxd      (uart_rxd),
        .rx_entry (rx_entry),
        .rx_valid (rx_valid)
    );

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held low for four cycles
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== dv/uart_bridge_tb.sv ====
`timescale 1ns/1ns

module uart_bridge_tb
    import uart_pkg::*;
;

    logic           clk;
    logic           rst_n;
    logic [7:0]     cmd_type;
    logic           cmd_start;
    cmd_beat_t      cmd_beat;
    logic           cmd_valid;
    logic           cmd_done;
    logic           cmd_ready;
    uart_rx_entry_t rsp;
    logic           rsp_valid;
    logic           rsp_ready;
    logic           uart_txd;
    logic           uart_rxd;
    logic           loop_sel;
    logic           bang_line;

    logic [7:0]     stim_mem [0:511];
    logic [7:0]     line_q [$];
    int             line_div = 16;
    int             line_bits = 8;
    logic           line_two_stop = 1'b0;
    logic [1:0]     line_par = 2'd0;
    logic [7:0]     line_mask = 8'hff;
    int             err_count = 0;
    int             tests_pass = 0;
    int             tests_fail = 0;
    logic           stall_seen;
    int             seed = 95;
    int             cycles = 0;
    int             limit_cycles = 2000;

    tb_clk_gen i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    // Loopback unless the testbench is injecting frames
    assign uart_rxd = loop_sel ? bang_line : uart_txd;

    uart_bridge_top i_uart_bridge_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_type  (cmd_type),
        .cmd_start (cmd_start),
        .cmd_beat  (cmd_beat),
        .cmd_valid (cmd_valid),
        .cmd_done  (cmd_done),
        .cmd_ready (cmd_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .uart_txd  (uart_txd),
        .uart_rxd  (uart_rxd)
    );

    task automatic check_eq(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got 0x%02h expected 0x%02h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("ERROR %s", what);
            err_count++;
        end
    endtask

    // Parity bit over the active data bits only
    function automatic logic parity_bit(input logic [7:0] d);
        return (^(d & line_mask)) ^ (line_par == 2'd1);
    endfunction

    task automatic wait_line_idle();
        int quiet;
        quiet = 0;
        while (quiet < 12 * line_div) begin
            @(negedge clk);
            quiet = uart_txd ? quiet + 1 : 0;
        end
    endtask

    task automatic start_command(input logic [7:0] kind);
        @(negedge clk);
        while (!cmd_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        cmd_type  <= kind;
        cmd_start <= 1'b1;
        @(posedge clk);
        cmd_start <= 1'b0;
    endtask

    // Beat is taken on the edge after a high cmd_ready is seen
    task automatic send_beat(input logic [7:0] data, input logic [2:0] index);
        @(posedge clk);
        cmd_beat  <= '{data: data, index: index};
        cmd_valid <= 1'b1;
        @(negedge clk);
        while (!cmd_ready) begin
            stall_seen = 1'b1;
            @(negedge clk);
        end
    endtask

    task automatic end_command();
        @(posedge clk);
        cmd_valid <= 1'b0;
        cmd_done  <= 1'b1;
        @(posedge clk);
        cmd_done  <= 1'b0;
    endtask

    task automatic do_config(input int base);
        int i;
        wait_line_idle();
        start_command(CMD_UART_CONFIG);
        for (i = 0; i < CFG_BYTES; i++) begin
            send_beat(stim_mem[base + i], 3'(i));
        end
        end_command();
        line_div      = int'({stim_mem[base], stim_mem[base + 1],
                              stim_mem[base + 2], stim_mem[base + 3]});
        line_bits     = int'(stim_mem[base + 4][3:0]);
        line_two_stop = |stim_mem[base + 5];
        line_par      = stim_mem[base + 6][1:0];
        line_mask     = 8'((1 << line_bits) - 1);
    endtask

    task automatic send_tx(input int base, input int n);
        int i;
        stall_seen = 1'b0;
        start_command(CMD_UART_TX);
        for (i = 0; i < n; i++) begin
            line_q.push_back(stim_mem[base + i] & line_mask);
            send_beat(stim_mem[base + i], 3'(i));
        end
        end_command();
        if (n > FIFO_DEPTH) begin
            check_true(stall_seen, "cmd_ready never dropped while the TX FIFO was full");
        end
    endtask

    task automatic collect_rx(input int base, input int n);
        int         got;
        logic [7:0] flags;
        logic [31:0] rnd;
        wait_line_idle();
        start_command(CMD_UART_RX);
        got = 0;
        while (got < n) begin
            @(posedge clk);
            rnd = $random(seed);
            rsp_ready <= (rnd[1:0] != 2'b00);
            @(negedge clk);
            if (rsp_valid && rsp_ready) begin
                flags = stim_mem[base + 2 * got + 1];
                check_eq("rsp.data", rsp.data, stim_mem[base + 2 * got]);
                check_eq("rsp.parity_err", 8'(rsp.parity_err), 8'(flags[1]));
                check_eq("rsp.frame_err", 8'(rsp.frame_err), 8'(flags[0]));
                got++;
            end
        end
        @(posedge clk);
        rsp_ready <= 1'b0;
        repeat (4) @(negedge clk);
        check_true(!rsp_valid, "RX FIFO holds more entries than expected");
        end_command();
    endtask

    task automatic send_line_bit(input logic b);
        @(posedge clk);
        bang_line <= b;
        repeat (line_div - 1) @(posedge clk);
    endtask

    // fault 1 flips the parity bit, fault 2 pulls the first stop bit low
    task automatic inject_frame(input logic [7:0] data, input logic [7:0] fault);
        int   i;
        logic par;
        par = parity_bit(data);
        send_line_bit(1'b0);
        for (i = 0; i < line_bits; i++) begin
            send_line_bit(data[i]);
        end
        if (line_par != 2'd0) begin
            send_line_bit(fault == 8'h01 ? ~par : par);
        end
        send_line_bit(fault != 8'h02);
        if (line_two_stop) begin
            send_line_bit(1'b1);
        end
        send_line_bit(1'b1);
        send_line_bit(1'b1);
    endtask

    task automatic inject_frames(input int base, input int n);
        int i;
        wait_line_idle();
        @(posedge clk);
        loop_sel <= 1'b1;
        for (i = 0; i < n; i++) begin
            inject_frame(stim_mem[base + 2 * i], stim_mem[base + 2 * i + 1]);
        end
        @(posedge clk);
        loop_sel <= 1'b0;
    endtask

    task automatic bad_command(input int base);
        int   i;
        logic quiet_ok;
        start_command(stim_mem[base]);
        for (i = 0; i < int'(stim_mem[base + 1]); i++) begin
            send_beat(stim_mem[base + 2 + i], 3'(i));
        end
        end_command();
        quiet_ok = 1'b1;
        repeat (200) begin
            @(negedge clk);
            if (!uart_txd || !cmd_ready) begin
                quiet_ok = 1'b0;
            end
        end
        check_true(quiet_ok, "line activity or low cmd_ready after an unknown command");
    endtask

    task automatic finish_test(input int num, input int errs_before);
        wait_line_idle();
        check_true(line_q.size() == 0, "frames missing on uart_txd");
        if (err_count == errs_before) begin
            tests_pass++;
            $display("test %0d ok", num);
        end else begin
            tests_fail++;
            $display("test %0d failed with %0d errors", num, err_count - errs_before);
        end
    endtask

    // Frames on the line times 12 bits at the slowest divisor
    task automatic compute_limit();
        int   p;
        int   frames;
        int   max_div;
        int   div;
        logic scanning;
        p        = 0;
        frames   = 0;
        max_div  = 16;
        scanning = 1'b1;
        while (scanning) begin
            case (stim_mem[p])
                8'h01: begin
                    div = int'({stim_mem[p + 1], stim_mem[p + 2], stim_mem[p + 3], stim_mem[p + 4]});
                    if (div > max_div) begin
                        max_div = div;
                    end
                    p += 8;
                end
                8'h02: begin
                    frames += int'(stim_mem[p + 1]);
                    p += 2 + int'(stim_mem[p + 1]);
                end
                8'h03: p += 2 + 2 * int'(stim_mem[p + 1]);
                8'h04: begin
                    frames += int'(stim_mem[p + 1]);
                    p += 2 + 2 * int'(stim_mem[p + 1]);
                end
                8'h05: p += 3 + int'(stim_mem[p + 2]);
                8'h06: p += 2;
                default: scanning = 1'b0;
            endcase
        end
        limit_cycles = frames * 12 * max_div + 2000;
    endtask

    // Decodes every frame leaving uart_txd, sampled mid-bit
    initial begin : line_decoder
        logic [7:0] bits;
        int         i;
        forever begin
            @(negedge clk);
            if (rst_n && !uart_txd) begin
                repeat (line_div / 2) @(negedge clk);
                check_true(!uart_txd, "start bit on uart_txd ended early");
                bits = '0;
                for (i = 0; i < line_bits; i++) begin
                    repeat (line_div) @(negedge clk);
                    bits[i] = uart_txd;
                end
                if (line_par != 2'd0) begin
                    repeat (line_div) @(negedge clk);
                    check_eq("uart_txd parity", 8'(uart_txd), 8'(parity_bit(bits)));
                end
                repeat (line_div) @(negedge clk);
                check_eq("uart_txd stop", 8'(uart_txd), 8'h01);
                if (line_two_stop) begin
                    repeat (line_div) @(negedge clk);
                    check_eq("uart_txd second stop", 8'(uart_txd), 8'h01);
                end
                if (line_q.size() == 0) begin
                    check_true(1'b0, "unexpected frame on uart_txd");
                end else begin
                    check_eq("uart_txd data", bits, line_q.pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit_cycles) begin
            $display("Run stopped by timeout after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        int         ptr;
        int         n;
        int         test_errs;
        logic       running;
        logic [7:0] op;
        cmd_type  = '0;
        cmd_start = 1'b0;
        cmd_beat  = '0;
        cmd_valid = 1'b0;
        cmd_done  = 1'b0;
        rsp_ready = 1'b0;
        loop_sel  = 1'b0;
        bang_line = 1'b1;
        $readmemh("dv/uart_stim.txt", stim_mem);
        compute_limit();
        wait (rst_n);
        @(negedge clk);
        test_errs = err_count;
        check_eq("uart_txd", 8'(uart_txd), 8'h01);
        check_eq("cmd_ready", 8'(cmd_ready), 8'h01);
        check_eq("rsp_valid", 8'(rsp_valid), 8'h00);
        ptr     = 0;
        running = 1'b1;
        while (running) begin
            op = stim_mem[ptr];
            n  = int'(stim_mem[ptr + 1]);
            case (op)
                8'h01: begin
                    do_config(ptr + 1);
                    ptr += 8;
                end
                8'h02: begin
                    send_tx(ptr + 2, n);
                    ptr += 2 + n;
                end
                8'h03: begin
                    collect_rx(ptr + 2, n);
                    ptr += 2 + 2 * n;
                end
                8'h04: begin
                    inject_frames(ptr + 2, n);
                    ptr += 2 + 2 * n;
                end
                8'h05: begin
                    bad_command(ptr + 1);
                    ptr += 3 + int'(stim_mem[ptr + 2]);
                end
                8'h06: begin
                    finish_test(n, test_errs);
                    test_errs = err_count;
                    ptr += 2;
                end
                8'h00: running = 1'b0;
                default: begin
                    check_true(1'b0, $sformatf("unknown op 0x%02h in stim file", op));
                    running = 1'b0;
                end
            endcase
        end
        $display("tests: %0d passed, %0d failed, %0d errors", tests_pass, tests_fail, err_count);
        if (tests_fail == 0 && err_count == 0 && tests_pass > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/uart_stim.txt ====
// Hex byte records, op then fields: 01 config (7 bytes), 02 tx (n, bytes), 03 rx (n, data+flags)
// 04 inject (n, data+fault), 05 unknown cmd (type, n, beats), 06 end of test (num), 00 stop
// Test 1 unknown command type
05 55 03 11 22 33
06 01
// Test 2 default loopback
02 05 a5 3c 00 ff 81
03 05 a5 00 3c 00 00 00 ff 00 81 00
06 02
// Test 3 divisor 8, 7 data bits, two stop, even parity
01 00 00 00 08 07 01 02
02 05 d5 2a 7f 80 c3
03 05 55 00 2a 00 7f 00 00 00 43 00
06 03
// Test 4 twenty bytes, only sixteen fit the RX FIFO
02 14 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f 20 21 22 23
03 10 10 00 11 00 12 00 13 00 14 00 15 00 16 00 17 00
18 00 19 00 1a 00 1b 00 1c 00 1d 00 1e 00 1f 00
06 04
// Test 5 bad parity then low stop bit
04 02 6e 01 b2 02
03 02 6e 02 32 01
06 05
00

// ==== sim.f ====
hw/uart_pkg.sv
hw/sync_fifo.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_handler.sv
hw/uart_bridge_top.sv
dv/tb_clk_gen.sv
dv/uart_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
    && rm -f sim.log \
    && verilator --binary --timing --assert -f sim.f --top-module uart_bridge_tb \
        -o uart_bridge_sim \
    && ./obj_dir/uart_bridge_sim | tee sim.log \
    && grep -q "TB PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
